// ==== logic/route_config.svh ====
`ifndef ROUTE_CONFIG_SVH
`define ROUTE_CONFIG_SVH

////////////////////////////////////////
// Switch geometry
////////////////////////////////////////

// Ethernet ports, also the width of every port mask
`define ROUTE_NETH 4

// Receive beat width, byte 0 sits in bits 7:0
`define ROUTE_DW 64

// MAC address width
`define ROUTE_MACW 48

////////////////////////////////////////
// Routing table
////////////////////////////////////////

// Log2 of the entry count, 8 entries
`define ROUTE_LGTBL 3

// Aging ticks until an unrefreshed entry drops out
`define ROUTE_AGE_MAX 3

// Aging period in cycles out of reset
`define ROUTE_AGE_PERIOD_RST 16'd1000

`endif

// ==== logic/route_pkg.sv ====
package route_pkg;

	////////////////////////////////////////
	// Receive side
	////////////////////////////////////////

	// Beat position inside a received frame
	typedef enum logic [1:0]
	{
		CAP_IDLE      = 2'd0,
		// Beat 0 taken, beat 1 still to come
		CAP_BEAT1     = 2'd1,
		// Source fully captured, waiting for the last beat
		CAP_WAIT_LAST = 2'd2
	} cap_state_e;

	////////////////////////////////////////
	// Lookup side
	////////////////////////////////////////

	// Outcome of a destination lookup
	typedef enum logic [1:0]
	{
		LKUP_HIT   = 2'd0,
		// Unknown unicast, floods
		LKUP_MISS  = 2'd1,
		// Multicast or broadcast, floods
		LKUP_GROUP = 2'd2
	} lkup_kind_e;

endpackage

// ==== logic/rx_src_mac_capture.sv ====
`timescale 1ns/10ps
`include "route_config.svh"

module rx_src_mac_capture
(
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_rx_valid,
	input  logic [`ROUTE_DW-1:0]   i_rx_data,
	input  logic                   i_rx_last,
	input  logic                   i_rx_abort,
	output logic                   o_learn,
	output logic [`ROUTE_MACW-1:0] o_learn_mac
);

	route_pkg::cap_state_e r_state;
	// Source bytes 6,7 from beat 0
	logic [15:0]           r_mac_hi;
	// Source bytes 8..11 from beat 1
	logic [31:0]           r_mac_lo;
	logic                  r_abort;
	logic                  r_group;
	logic                  beat_abort;
	logic                  frame_good;

	// Abort seen anywhere in the frame up to and including this beat
	assign beat_abort = r_abort | i_rx_abort;

	// Closing beat of a clean frame of two or more beats with a unicast source
	// Single-beat frames close in CAP_IDLE and never qualify
	assign frame_good = i_rx_valid && i_rx_last
		&& (r_state != route_pkg::CAP_IDLE)
		&& !beat_abort && !r_group;

	// Byte 6 is the most significant byte of the address
	assign o_learn_mac = {r_mac_hi, r_mac_lo};

	////////////////////////////////////////
	// Frame position FSM
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			r_state <= route_pkg::CAP_IDLE;
			r_abort <= 1'b0;
			r_group <= 1'b0;
			o_learn <= 1'b0;
		end
		else
		begin
			// Strobe lands one cycle after the last beat
			o_learn <= frame_good;
			if (i_rx_valid)
			begin
				case (r_state)
				route_pkg::CAP_IDLE:
				begin
					// First beat restarts the abort history
					r_abort <= i_rx_abort;
					// Group bit is bit 0 of byte 6
					r_group <= i_rx_data[48];
					if (!i_rx_last)
						r_state <= route_pkg::CAP_BEAT1;
				end
				route_pkg::CAP_BEAT1:
				begin
					r_abort <= beat_abort;
					if (i_rx_last)
						r_state <= route_pkg::CAP_IDLE;
					else
						r_state <= route_pkg::CAP_WAIT_LAST;
				end
				route_pkg::CAP_WAIT_LAST:
				begin
					r_abort <= beat_abort;
					if (i_rx_last)
						r_state <= route_pkg::CAP_IDLE;
				end
				default:
					r_state <= route_pkg::CAP_IDLE;
				endcase
			end
		end
	end

	// Address bytes, reordered so byte 6 lands on top
	always_ff @(posedge i_clk)
	begin
		if (i_rx_valid && (r_state == route_pkg::CAP_IDLE))
			r_mac_hi <= {i_rx_data[55:48], i_rx_data[63:56]};
		if (i_rx_valid && (r_state == route_pkg::CAP_BEAT1))
			r_mac_lo <= {i_rx_data[7:0], i_rx_data[15:8],
				i_rx_data[23:16], i_rx_data[31:24]};
	end

endmodule

// ==== logic/learn_arbiter.sv ====
`timescale 1ns/10ps
`include "route_config.svh"

module learn_arbiter
(
	input  logic                                i_clk,
	input  logic                                i_rst_n,
	input  logic [`ROUTE_NETH-1:0]              i_learn,
	input  logic [`ROUTE_NETH*`ROUTE_MACW-1:0]  i_learn_mac,
	input  logic [`ROUTE_NETH-1:0]              i_port_en,
	output logic                                o_wr,
	output logic [`ROUTE_MACW-1:0]              o_wr_mac,
	output logic [$clog2(`ROUTE_NETH)-1:0]      o_wr_port
);

	localparam int NETH = `ROUTE_NETH;
	localparam int MACW = `ROUTE_MACW;
	localparam int PW   = $clog2(`ROUTE_NETH);

	// One pending learn per port
	logic [NETH-1:0] r_pend;
	logic [MACW-1:0] r_mac [NETH];
	// Last port granted, search starts just after it
	logic [PW-1:0]   r_last;
	logic [PW-1:0]   cand;
	logic [PW-1:0]   gnt_idx;
	logic            gnt_vld;
	logic [NETH-1:0] accept;

	// Disabled ports never get a pending slot
	assign accept = i_learn & i_port_en;

	////////////////////////////////////////
	// Round-robin pick
	////////////////////////////////////////
	always_comb
	begin
		gnt_vld = 1'b0;
		gnt_idx = r_last;
		cand    = r_last;
		// Offsets 1..NETH wrap back onto r_last last
		for (int k = 1; k <= NETH; k++)
		begin
			cand = r_last + PW'(k);
			if (!gnt_vld && r_pend[cand])
			begin
				gnt_vld = 1'b1;
				gnt_idx = cand;
			end
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			r_pend <= '0;
			r_last <= '0;
			o_wr   <= 1'b0;
		end
		else
		begin
			o_wr <= gnt_vld;
			if (gnt_vld)
				r_last <= gnt_idx;
			for (int p = 0; p < NETH; p++)
			begin
				// A fresh learn beats the grant of the older one
				if (accept[p])
					r_pend[p] <= 1'b1;
				else if (gnt_vld && (gnt_idx == PW'(p)))
					r_pend[p] <= 1'b0;
			end
		end
	end

	// Newer learn overwrites the pending address
	always_ff @(posedge i_clk)
	begin
		for (int p = 0; p < NETH; p++)
		begin
			if (accept[p])
				r_mac[p] <= i_learn_mac[p*MACW +: MACW];
		end
		if (gnt_vld)
		begin
			o_wr_mac  <= r_mac[gnt_idx];
			o_wr_port <= gnt_idx;
		end
	end

endmodule

// ==== logic/route_cfg_regs.sv ====
`timescale 1ns/10ps
`include "route_config.svh"

module route_cfg_regs
(
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_cfg_wr,
	input  logic [1:0]             i_cfg_addr,
	input  logic [15:0]            i_cfg_wdata,
	output logic [15:0]            o_cfg_rdata,
	output logic [`ROUTE_NETH-1:0] o_port_en,
	output logic                   o_age_tick
);

	logic [`ROUTE_NETH-1:0] r_port_en;
	logic [15:0]            r_age_period;
	// Cycles left until the next tick
	logic [15:0]            r_age_cnt;

	assign o_port_en = r_port_en;

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			r_port_en    <= '1;
			r_age_period <= `ROUTE_AGE_PERIOD_RST;
		end
		else if (i_cfg_wr)
		begin
			case (i_cfg_addr)
			2'd0: r_port_en <= i_cfg_wdata[`ROUTE_NETH-1:0];
			2'd1: r_age_period <= i_cfg_wdata;
			default: ;
			endcase
		end
	end

	// Readback, unused addresses return zero
	always_comb
	begin
		case (i_cfg_addr)
		2'd0: o_cfg_rdata = 16'(r_port_en);
		2'd1: o_cfg_rdata = r_age_period;
		default: o_cfg_rdata = 16'd0;
		endcase
	end

	////////////////////////////////////////
	// Aging tick
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			r_age_cnt  <= `ROUTE_AGE_PERIOD_RST - 16'd1;
			o_age_tick <= 1'b0;
		end
		else
		begin
			o_age_tick <= 1'b0;
			// Period write restarts the count
			if (i_cfg_wr && (i_cfg_addr == 2'd1))
				r_age_cnt <= i_cfg_wdata - 16'd1;
			// Zero period holds the counter, no ticks
			else if (r_age_period != 16'd0)
			begin
				if (r_age_cnt == 16'd0)
				begin
					o_age_tick <= 1'b1;
					r_age_cnt  <= r_age_period - 16'd1;
				end
				else
					r_age_cnt <= r_age_cnt - 16'd1;
			end
		end
	end

endmodule

// ==== logic/route_table.sv ====
`timescale 1ns/10ps
`include "route_config.svh"

module route_table
(
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic                           i_wr,
	input  logic [`ROUTE_MACW-1:0]         i_wr_mac,
	input  logic [$clog2(`ROUTE_NETH)-1:0] i_wr_port,
	input  logic                           i_age_tick,
	input  logic [`ROUTE_NETH-1:0]         i_port_en,
	input  logic                           i_lkup_req,
	input  logic [`ROUTE_MACW-1:0]         i_lkup_mac,
	input  logic [$clog2(`ROUTE_NETH)-1:0] i_lkup_src_port,
	output logic                           o_lkup_ack,
	output logic [`ROUTE_NETH-1:0]         o_lkup_ports,
	output route_pkg::lkup_kind_e          o_lkup_kind
);

	localparam int NETH = `ROUTE_NETH;
	localparam int PW   = $clog2(`ROUTE_NETH);
	localparam int LG   = `ROUTE_LGTBL;
	localparam int NTBL = 1 << `ROUTE_LGTBL;
	localparam int AGEW = $clog2(`ROUTE_AGE_MAX + 1);
	// Age at which the next tick removes the entry
	localparam logic [AGEW-1:0] AGE_LAST = AGEW'(`ROUTE_AGE_MAX - 1);

	// Entry storage
	logic [NTBL-1:0]         r_valid;
	logic [`ROUTE_MACW-1:0]  r_mac [NTBL];
	logic [PW-1:0]           r_port [NTBL];
	logic [AGEW-1:0]         r_age [NTBL];

	// Write target selection
	logic                    match_vld;
	logic                    free_vld;
	logic [LG-1:0]           match_idx;
	logic [LG-1:0]           free_idx;
	logic [LG-1:0]           old_idx;
	logic [AGEW-1:0]         old_age;
	logic [LG-1:0]           wr_idx;

	// Lookup pipeline
	logic [NTBL-1:0]         lk_match;
	logic                    r1_req;
	logic [NTBL-1:0]         r1_match;
	logic                    r1_group;
	logic [PW-1:0]           r1_src;
	logic [PW-1:0]           hit_port;
	logic [NETH-1:0]         flood;
	logic [NETH-1:0]         res_ports;
	route_pkg::lkup_kind_e   res_kind;

	////////////////////////////////////////
	// Learning
	////////////////////////////////////////
	always_comb
	begin
		match_vld = 1'b0;
		free_vld  = 1'b0;
		match_idx = '0;
		free_idx  = '0;
		old_idx   = '0;
		old_age   = r_age[0];
		for (int i = 0; i < NTBL; i++)
		begin
			// Same address already present
			if (!match_vld && r_valid[i] && (r_mac[i] == i_wr_mac))
			begin
				match_vld = 1'b1;
				match_idx = LG'(i);
			end
			// Lowest empty slot
			if (!free_vld && !r_valid[i])
			begin
				free_vld = 1'b1;
				free_idx = LG'(i);
			end
			// Oldest entry, strict compare keeps the lowest index on ties
			if (r_age[i] > old_age)
			begin
				old_age = r_age[i];
				old_idx = LG'(i);
			end
		end
		if (match_vld)
			wr_idx = match_idx;
		else if (free_vld)
			wr_idx = free_idx;
		else
			wr_idx = old_idx;
	end

	// Valid and age, a write to an entry wins over the tick
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			r_valid <= '0;
			for (int i = 0; i < NTBL; i++)
				r_age[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < NTBL; i++)
			begin
				if (i_wr && (wr_idx == LG'(i)))
				begin
					r_valid[i] <= 1'b1;
					r_age[i]   <= '0;
				end
				else if (i_age_tick && r_valid[i])
				begin
					if (r_age[i] == AGE_LAST)
						r_valid[i] <= 1'b0;
					r_age[i] <= r_age[i] + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_wr)
		begin
			r_mac[wr_idx]  <= i_wr_mac;
			r_port[wr_idx] <= i_wr_port;
		end
	end

	////////////////////////////////////////
	// Lookup stage 1, match
	////////////////////////////////////////
	always_comb
	begin
		for (int i = 0; i < NTBL; i++)
			lk_match[i] = r_valid[i] && (r_mac[i] == i_lkup_mac);
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			r1_req <= 1'b0;
		else
			r1_req <= i_lkup_req;
	end

	always_ff @(posedge i_clk)
	begin
		r1_match <= lk_match;
		// Group bit is bit 0 of the first address byte
		r1_group <= i_lkup_mac[40];
		r1_src   <= i_lkup_src_port;
	end

	////////////////////////////////////////
	// Lookup stage 2, result
	////////////////////////////////////////
	always_comb
	begin
		hit_port = '0;
		// At most one entry matches since writes merge duplicates
		for (int i = 0; i < NTBL; i++)
		begin
			if (r1_match[i])
				hit_port = hit_port | r_port[i];
		end
		// Enabled ports minus the asker
		flood = i_port_en & ~(NETH'(1) << r1_src);
		if (r1_group)
		begin
			res_kind  = route_pkg::LKUP_GROUP;
			res_ports = flood;
		end
		else if (|r1_match)
		begin
			// May come out zero when the learned port is the asker
			res_kind  = route_pkg::LKUP_HIT;
			res_ports = (NETH'(1) << hit_port) & flood;
		end
		else
		begin
			res_kind  = route_pkg::LKUP_MISS;
			res_ports = flood;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			o_lkup_ack <= 1'b0;
		else
			o_lkup_ack <= r1_req;
	end

	always_ff @(posedge i_clk)
	begin
		o_lkup_ports <= res_ports;
		o_lkup_kind  <= res_kind;
	end

endmodule

// ==== logic/route_core.sv ====
`timescale 1ns/10ps
`include "route_config.svh"

module route_core
(
	input  logic                                i_clk,
	input  logic                                i_rst_n,
	// Receive lanes, port g in slice g
	input  logic [`ROUTE_NETH-1:0]              i_rx_valid,
	input  logic [`ROUTE_NETH*`ROUTE_DW-1:0]    i_rx_data,
	input  logic [`ROUTE_NETH-1:0]              i_rx_last,
	input  logic [`ROUTE_NETH-1:0]              i_rx_abort,
	// Register writes
	input  logic                                i_cfg_wr,
	input  logic [1:0]                          i_cfg_addr,
	input  logic [15:0]                         i_cfg_wdata,
	output logic [15:0]                         o_cfg_rdata,
	// Destination lookup
	input  logic                                i_lkup_req,
	input  logic [`ROUTE_MACW-1:0]              i_lkup_mac,
	input  logic [$clog2(`ROUTE_NETH)-1:0]      i_lkup_src_port,
	output logic                                o_lkup_ack,
	output logic [`ROUTE_NETH-1:0]              o_lkup_ports,
	output route_pkg::lkup_kind_e               o_lkup_kind
);

	logic [`ROUTE_NETH-1:0]             learn;
	logic [`ROUTE_NETH*`ROUTE_MACW-1:0] learn_mac;
	logic                               wr;
	logic [`ROUTE_MACW-1:0]             wr_mac;
	logic [$clog2(`ROUTE_NETH)-1:0]     wr_port;
	logic [`ROUTE_NETH-1:0]             port_en;
	logic                               age_tick;

	////////////////////////////////////////
	// Per-port source capture
	////////////////////////////////////////
	genvar g;
	generate
		for (g = 0; g < `ROUTE_NETH; g++)
		begin : g_cap
			rx_src_mac_capture u_cap
			(
				.i_clk       (i_clk),
				.i_rst_n     (i_rst_n),
				.i_rx_valid  (i_rx_valid[g]),
				.i_rx_data   (i_rx_data[g*`ROUTE_DW +: `ROUTE_DW]),
				.i_rx_last   (i_rx_last[g]),
				.i_rx_abort  (i_rx_abort[g]),
				.o_learn     (learn[g]),
				.o_learn_mac (learn_mac[g*`ROUTE_MACW +: `ROUTE_MACW])
			);
		end
	endgenerate

	// Funnel all learns into the single table write port
	learn_arbiter u_arb
	(
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_learn     (learn),
		.i_learn_mac (learn_mac),
		.i_port_en   (port_en),
		.o_wr        (wr),
		.o_wr_mac    (wr_mac),
		.o_wr_port   (wr_port)
	);

	route_cfg_regs u_cfg
	(
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_cfg_wr    (i_cfg_wr),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wdata (i_cfg_wdata),
		.o_cfg_rdata (o_cfg_rdata),
		.o_port_en   (port_en),
		.o_age_tick  (age_tick)
	);

	route_table u_tbl
	(
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_wr            (wr),
		.i_wr_mac        (wr_mac),
		.i_wr_port       (wr_port),
		.i_age_tick      (age_tick),
		.i_port_en       (port_en),
		.i_lkup_req      (i_lkup_req),
		.i_lkup_mac      (i_lkup_mac),
		.i_lkup_src_port (i_lkup_src_port),
		.o_lkup_ack      (o_lkup_ack),
		.o_lkup_ports    (o_lkup_ports),
		.o_lkup_kind     (o_lkup_kind)
	);

endmodule

// ==== test/route_core_asserts.sv ====
`timescale 1ns/10ps
`include "route_config.svh"

module route_core_asserts
(
	input  logic                           i_clk,
	input  logic                           i_rst_n,
	input  logic                           i_lkup_req,
	input  logic [$clog2(`ROUTE_NETH)-1:0] i_lkup_src_port,
	input  logic                           i_lkup_ack,
	input  logic [`ROUTE_NETH-1:0]         i_lkup_ports,
	input  route_pkg::lkup_kind_e          i_lkup_kind
);

	localparam int NETH = `ROUTE_NETH;

	////////////////////////////////////////
	// Lookup timing
	////////////////////////////////////////

	// Ack exactly two cycles after each request, and never without one
	a_ack_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_lkup_ack == $past(i_lkup_req, 2))
	else
		$error("lookup ack does not trail the request by two cycles");

	////////////////////////////////////////
	// Result masks
	////////////////////////////////////////

	// A hit names one port at most
	a_hit_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_lkup_ack && (i_lkup_kind == route_pkg::LKUP_HIT)) |-> $onehot0(i_lkup_ports))
	else
		$error("hit mask has more than one port set");

	// Flooding never goes back to the asker
	a_flood_no_src: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_lkup_ack && (i_lkup_kind != route_pkg::LKUP_HIT))
		|-> ((i_lkup_ports & (NETH'(1) << $past(i_lkup_src_port, 2))) == '0))
	else
		$error("flood mask contains the source port");

endmodule

// ==== test/route_core_tb.sv ====
`timescale 1ns/10ps
`include "route_config.svh"

module route_core_tb;

	localparam int NETH = `ROUTE_NETH;
	localparam int DW   = `ROUTE_DW;
	localparam int MACW = `ROUTE_MACW;
	localparam int PW   = $clog2(`ROUTE_NETH);
	// The six tests take about 500 cycles in all
	localparam int TIMEOUT_CYCLES = 20000;
	// Frame to lookup spacing
	// Covers a learn path of at most NETH+3 cycles
	localparam int LEARN_WAIT = 8;

	logic                    clk;
	logic                    rst_n;
	logic [NETH-1:0]         rx_valid;
	logic [NETH*DW-1:0]      rx_data;
	logic [NETH-1:0]         rx_last;
	logic [NETH-1:0]         rx_abort;
	logic                    cfg_wr;
	logic [1:0]              cfg_addr;
	logic [15:0]             cfg_wdata;
	logic [15:0]             cfg_rdata;
	logic                    lkup_req;
	logic [MACW-1:0]         lkup_mac;
	logic [PW-1:0]           lkup_src;
	logic                    lkup_ack;
	logic [NETH-1:0]         lkup_ports;
	route_pkg::lkup_kind_e   lkup_kind;

	// Bookkeeping
	logic [31:0]             lfsr_state = 32'h2620_7ae8;
	logic [NETH-1:0]         port_en_model;
	string                   cur_test;
	int                      err_count;
	int                      check_count;
	int                      test_count;
	int                      test_err_start;
	int                      cycle_count;
	logic [MACW-1:0]         moved_mac;

	route_core u_dut
	(
		.i_clk           (clk),
		.i_rst_n         (rst_n),
		.i_rx_valid      (rx_valid),
		.i_rx_data       (rx_data),
		.i_rx_last       (rx_last),
		.i_rx_abort      (rx_abort),
		.i_cfg_wr        (cfg_wr),
		.i_cfg_addr      (cfg_addr),
		.i_cfg_wdata     (cfg_wdata),
		.o_cfg_rdata     (cfg_rdata),
		.i_lkup_req      (lkup_req),
		.i_lkup_mac      (lkup_mac),
		.i_lkup_src_port (lkup_src),
		.o_lkup_ack      (lkup_ack),
		.o_lkup_ports    (lkup_ports),
		.o_lkup_kind     (lkup_kind)
	);

	bind route_table route_core_asserts u_asserts
	(
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_lkup_req      (i_lkup_req),
		.i_lkup_src_port (i_lkup_src_port),
		.i_lkup_ack      (o_lkup_ack),
		.i_lkup_ports    (o_lkup_ports),
		.i_lkup_kind     (o_lkup_kind)
	);

	////////////////////////////////////////
	// Clock and run limit
	////////////////////////////////////////
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Galois LFSR on x^32+x^22+x^2+x+1
	// One step per bit taken
	function automatic logic [63:0] lfsr_bits(input int n);
		logic [63:0] v;
		logic        b;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			b = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (b)
				lfsr_state = lfsr_state ^ 32'h8020_0003;
			v = {v[62:0], b};
		end
		return v;
	endfunction

	// Random address with the group bit of the first byte cleared
	function automatic logic [MACW-1:0] rand_unicast_mac();
		logic [63:0] v;
		v = lfsr_bits(MACW);
		v[40] = 1'b0;
		return v[MACW-1:0];
	endfunction

	task automatic compare_value(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		check_count++;
		assert (act === exp)
		else
		begin
			$display("FAILED %s: %s expected %0h actual %0h", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_err_start = err_count;
	endtask

	task automatic end_test();
		test_count++;
		$display("[%0d] %s finished with %0d errors", test_count, cur_test,
			err_count - test_err_start);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// Table write strobes seen over the next n cycles
	task automatic count_table_writes(input int n, output int writes);
		writes = 0;
		repeat (n)
		begin
			@(negedge clk);
			if (u_dut.wr)
				writes++;
		end
	endtask

	task automatic write_register(input logic [1:0] addr, input logic [15:0] data);
		@(posedge clk);
		cfg_wr    <= 1'b1;
		cfg_addr  <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_wr    <= 1'b0;
		if (addr == 2'd0)
			port_en_model = data[NETH-1:0];
	endtask

	task automatic check_readback(input logic [1:0] addr, input logic [15:0] exp);
		@(posedge clk);
		cfg_addr <= addr;
		// Combinational readback settles by the falling edge
		@(negedge clk);
		compare_value("cfg readback", 64'(exp), 64'(cfg_rdata));
	endtask

	// Two-beat frame with the source in bytes 6..11
	// Abort is raised on the closing beat
	task automatic send_frame(input int port, input logic [MACW-1:0] mac, input bit abort);
		logic [63:0] pad0;
		logic [63:0] pad1;
		logic [63:0] beat0;
		logic [63:0] beat1;
		pad0  = lfsr_bits(48);
		pad1  = lfsr_bits(32);
		beat0 = {mac[39:32], mac[47:40], pad0[47:0]};
		beat1 = {pad1[31:0], mac[7:0], mac[15:8], mac[23:16], mac[31:24]};
		@(posedge clk);
		rx_valid[port]           <= 1'b1;
		rx_data[port*DW +: DW]   <= beat0;
		rx_last[port]            <= 1'b0;
		rx_abort[port]           <= 1'b0;
		@(posedge clk);
		rx_data[port*DW +: DW]   <= beat1;
		rx_last[port]            <= 1'b1;
		rx_abort[port]           <= abort;
		@(posedge clk);
		rx_valid[port]           <= 1'b0;
		rx_last[port]            <= 1'b0;
		rx_abort[port]           <= 1'b0;
	endtask

	// Learned is the port the address was learned on or -1 when unknown
	task automatic lookup(input logic [MACW-1:0] mac, input int src, input int learned);
		route_pkg::lkup_kind_e exp_kind;
		logic [NETH-1:0]       flood;
		logic [NETH-1:0]       exp_ports;
		int                    cycles;
		bit                    got_ack;
		flood = port_en_model & ~(NETH'(1) << src);
		if (mac[40])
		begin
			exp_kind  = route_pkg::LKUP_GROUP;
			exp_ports = flood;
		end
		else if (learned >= 0)
		begin
			exp_kind  = route_pkg::LKUP_HIT;
			exp_ports = (NETH'(1) << learned) & flood;
		end
		else
		begin
			exp_kind  = route_pkg::LKUP_MISS;
			exp_ports = flood;
		end
		@(posedge clk);
		lkup_req <= 1'b1;
		lkup_mac <= mac;
		lkup_src <= PW'(src);
		@(posedge clk);
		lkup_req <= 1'b0;
		cycles  = 1;
		got_ack = 1'b0;
		while (!got_ack && (cycles < 8))
		begin
			@(negedge clk);
			if (lkup_ack)
				got_ack = 1'b1;
			else
			begin
				@(posedge clk);
				cycles++;
			end
		end
		check_count++;
		assert (got_ack)
		else
		begin
			$display("%s: no lookup acknowledge within 8 cycles", cur_test);
			err_count++;
		end
		if (got_ack)
		begin
			compare_value("ack latency", 64'(2), 64'(cycles));
			compare_value("kind", 64'(exp_kind), 64'(lkup_kind));
			compare_value("ports", 64'(exp_ports), 64'(lkup_ports));
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	task automatic learn_and_hit();
		start_test("learn_hit");
		moved_mac = rand_unicast_mac();
		send_frame(2, moved_mac, 1'b0);
		wait_cycles(LEARN_WAIT);
		lookup(moved_mac, 0, 2);
		// Asking from the learned port leaves nothing to send
		lookup(moved_mac, 2, 2);
		end_test();
	endtask

	task automatic flood_unknown_and_group();
		start_test("flooding");
		lookup(rand_unicast_mac(), 1, -1);
		lookup(48'hffff_ffff_ffff, 3, -1);
		lookup(48'h0100_5e00_0001, 0, -1);
		end_test();
	endtask

	task automatic filter_and_move();
		logic [MACW-1:0] aborted_mac;
		logic [MACW-1:0] group_src;
		int              writes;
		start_test("filters");
		aborted_mac = rand_unicast_mac();
		send_frame(1, aborted_mac, 1'b1);
		wait_cycles(LEARN_WAIT);
		lookup(aborted_mac, 0, -1);
		group_src = rand_unicast_mac() | 48'h0100_0000_0000;
		send_frame(0, group_src, 1'b0);
		// A group source leaves the table untouched
		count_table_writes(LEARN_WAIT, writes);
		compare_value("group source writes", 64'(0), 64'(writes));
		lookup(group_src, 2, -1);
		// Station moved to another port
		send_frame(3, moved_mac, 1'b0);
		wait_cycles(LEARN_WAIT);
		lookup(moved_mac, 0, 3);
		end_test();
	endtask

	task automatic disabled_port();
		logic [MACW-1:0] off_mac;
		start_test("port_enable");
		write_register(2'd0, 16'h000d);
		check_readback(2'd0, 16'h000d);
		off_mac = rand_unicast_mac();
		send_frame(1, off_mac, 1'b0);
		wait_cycles(LEARN_WAIT);
		lookup(off_mac, 0, -1);
		lookup(rand_unicast_mac(), 2, -1);
		lookup(moved_mac, 1, 3);
		write_register(2'd0, 16'h000f);
		end_test();
	endtask

	task automatic entry_aging();
		logic [MACW-1:0] stale_mac;
		logic [MACW-1:0] fresh_mac;
		start_test("aging");
		write_register(2'd1, 16'd20);
		check_readback(2'd1, 16'd20);
		stale_mac = rand_unicast_mac();
		fresh_mac = rand_unicast_mac();
		send_frame(0, stale_mac, 1'b0);
		// Refresh every 30 cycles so at most two ticks fall in between
		for (int i = 0; i < 4; i++)
		begin
			send_frame(1, fresh_mac, 1'b0);
			wait_cycles(27);
		end
		lookup(fresh_mac, 2, 1);
		lookup(stale_mac, 2, -1);
		end_test();
	endtask

	task automatic full_table_replace();
		logic [MACW-1:0] macs [9];
		start_test("replacement");
		// Let every older entry age out first
		wait_cycles(80);
		write_register(2'd1, 16'd0);
		for (int i = 0; i < 9; i++)
		begin
			macs[i] = rand_unicast_mac();
			send_frame(i % NETH, macs[i], 1'b0);
			wait_cycles(LEARN_WAIT);
		end
		// All ages equal so the lowest slot holding the first address goes
		lookup(macs[0], 1, -1);
		for (int i = 1; i < 9; i++)
			lookup(macs[i], (i + 1) % NETH, i % NETH);
		end_test();
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial
	begin
		rst_n         = 1'b0;
		rx_valid      = '0;
		rx_data       = '0;
		rx_last       = '0;
		rx_abort      = '0;
		cfg_wr        = 1'b0;
		cfg_addr      = 2'd0;
		cfg_wdata     = 16'd0;
		lkup_req      = 1'b0;
		lkup_mac      = '0;
		lkup_src      = '0;
		port_en_model = '1;
		err_count     = 0;
		check_count   = 0;
		test_count    = 0;
		cycle_count   = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		wait_cycles(2);
		learn_and_hit();
		flood_unknown_and_group();
		filter_and_move();
		disabled_port();
		entry_aging();
		full_table_replace();
		wait_cycles(4);
		$display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
			err_count);
		if (err_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+logic
logic/route_pkg.sv
logic/rx_src_mac_capture.sv
logic/learn_arbiter.sv
logic/route_cfg_regs.sv
logic/route_table.sv
logic/route_core.sv
test/route_core_asserts.sv
test/route_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module route_core_tb -f flist.f

out=$(./obj_dir/Vroute_core_tb)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi
